// ==== common/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// --------------------
// Clock and line rate
// --------------------

// System clock in Hz
`define CLK_FREQ 125_000_000

// Serial rate, sixteen clocks per bit
`define BAUD_RATE 7_812_500

// --------------------
// Hub sizing
// --------------------

`define UART_CHANNELS 2

// Entries in the shared receive FIFO, power of two
`define RX_FIFO_DEPTH 8

`endif

// ==== common/uart_pkg.sv ====
`include "uart_config.svh"

package uart_pkg;

	// --------------------
	// Channel index
	// --------------------

	// Never narrower than one bit, even for a single channel
	localparam int CHAN_W = (`UART_CHANNELS > 1) ? $clog2(`UART_CHANNELS) : 1;

	typedef logic [CHAN_W-1:0] chan_t;

	// --------------------
	// Receive FIFO entry
	// --------------------

	// Source channel in the top bits
	// Bad stop bit still keeps the sampled data
	typedef struct packed {
		chan_t      chan;
		logic       frame_err;
		logic [7:0] data;
	} rx_entry_t;

endpackage

// ==== uart_rx/uart_rx.sv ====
`timescale 1ns/1ps

`include "uart_config.svh"

module uart_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx,
	output logic       byte_valid,
	output logic       frame_err,
	output logic [7:0] data
);

	localparam int CLKS_PER_BIT = `CLK_FREQ / `BAUD_RATE;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP,
		ST_WAIT_HIGH
	} state_t;

	state_t           state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] bit_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;
	logic             cnt_half;
	logic             cnt_last;

	// --------------------
	// Input synchronizer
	// --------------------

	// Both flops come out of reset at the idle level
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// --------------------
	// Bit timing
	// --------------------

	assign cnt_half = (bit_cnt == CNT_W'(HALF_BIT - 1));
	assign cnt_last = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// --------------------
	// Frame FSM
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_WAIT_HIGH;
			bit_cnt    <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;

			case (state)
				ST_IDLE: begin
					bit_cnt <= '0;
					if (!rx_sync)
						state <= ST_START;
				end

				ST_START: begin
					if (cnt_half) begin
						bit_cnt <= '0;
						bit_idx <= '0;
						// Line back high at mid start bit, just a glitch
						state   <= rx_sync ? ST_IDLE : ST_DATA;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end

				ST_DATA: begin
					if (cnt_last) begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= ST_STOP;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end

				ST_STOP: begin
					if (cnt_last) begin
						bit_cnt    <= '0;
						byte_valid <= rx_sync;
						frame_err  <= !rx_sync;
						state      <= ST_WAIT_HIGH;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end

				// Hold off until the line returns to idle
				ST_WAIT_HIGH: begin
					bit_cnt <= '0;
					if (rx_sync)
						state <= ST_IDLE;
				end

				default: begin
					state <= ST_WAIT_HIGH;
				end
			endcase
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (state == ST_DATA && cnt_last)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

	assign data = shift_reg;

endmodule

// ==== source/rx_arbiter.sv ====
`timescale 1ns/1ps

`include "uart_config.svh"

module rx_arbiter (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [`UART_CHANNELS-1:0]      byte_valid,
	input  logic [`UART_CHANNELS-1:0]      frame_err,
	input  logic [`UART_CHANNELS-1:0][7:0] data,
	input  logic                           full,
	output logic                           push,
	output uart_pkg::rx_entry_t            push_entry,
	output logic [`UART_CHANNELS-1:0]      overrun
);

	import uart_pkg::*;

	localparam int N = `UART_CHANNELS;

	rx_entry_t    held [N];
	logic [N-1:0] pend;
	logic         grant_any;
	chan_t        grant_idx;
	chan_t        last_grant;

	// --------------------
	// Round robin grant
	// --------------------

	// Search starts one past the last winner
	always_comb begin
		int idx;
		grant_any = 1'b0;
		grant_idx = last_grant;
		for (int off = 1; off <= N; off++) begin
			idx = (int'(last_grant) + off) % N;
			if (!grant_any && pend[idx]) begin
				grant_any = 1'b1;
				grant_idx = chan_t'(idx);
			end
		end
	end

	assign push       = grant_any && !full;
	assign push_entry = held[grant_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			last_grant <= chan_t'(N - 1);
		else if (push)
			last_grant <= grant_idx;
	end

	// --------------------
	// Holding registers
	// --------------------

	for (genvar i = 0; i < N; i++) begin : g_chan
		logic      pulse;
		logic      taken;
		logic      accept;
		logic      pend_q;
		logic      ovr_q;
		rx_entry_t hold_q;

		assign pulse  = byte_valid[i] | frame_err[i];
		assign taken  = push && (grant_idx == chan_t'(i));
		// A slot being pushed this cycle can take the next frame
		assign accept = pulse && (!pend_q || taken);

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				pend_q <= 1'b0;
				ovr_q  <= 1'b0;
			end else begin
				if (pulse && !accept)
					ovr_q <= 1'b1;
				if (accept)
					pend_q <= 1'b1;
				else if (taken)
					pend_q <= 1'b0;
			end
		end

		always_ff @(posedge clk) begin
			if (accept)
				hold_q <= '{chan: chan_t'(i), frame_err: frame_err[i], data: data[i]};
		end

		assign pend[i]    = pend_q;
		assign held[i]    = hold_q;
		assign overrun[i] = ovr_q;
	end

endmodule

// ==== source/rx_fifo.sv ====
`timescale 1ns/1ps

`include "uart_config.svh"

module rx_fifo (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                push,
	input  uart_pkg::rx_entry_t push_entry,
	input  logic                rd_en,
	output uart_pkg::rx_entry_t head,
	output logic                empty,
	output logic                full
);

	import uart_pkg::*;

	localparam int DEPTH = `RX_FIFO_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	rx_entry_t   mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        do_push;
	logic        do_pop;

	// --------------------
	// Status
	// --------------------

	// Extra pointer bit tells full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
	               (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Writes while full and reads while empty are dropped
	assign do_push = push && !full;
	assign do_pop  = rd_en && !empty;

	// --------------------
	// Pointers
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (do_push) begin
			wr_ptr <= wr_ptr + (AW + 1)'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (do_pop) begin
			rd_ptr <= rd_ptr + (AW + 1)'(1);
		end
	end

	// --------------------
	// Storage
	// --------------------

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= push_entry;
	end

	// Head is valid whenever empty is low
	assign head = mem[rd_ptr[AW-1:0]];

endmodule

// ==== source/uart_hub_top.sv ====
`timescale 1ns/1ps

`include "uart_config.svh"

module uart_hub_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`UART_CHANNELS-1:0] rx,
	input  logic                      rd_en,
	output uart_pkg::rx_entry_t       entry,
	output logic                      empty,
	output logic [`UART_CHANNELS-1:0] overrun
);

	import uart_pkg::*;

	localparam int N = `UART_CHANNELS;

	logic [N-1:0]      byte_valid;
	logic [N-1:0]      frame_err;
	logic [N-1:0][7:0] rx_data;
	logic              push;
	rx_entry_t         push_entry;
	logic              full;

	// --------------------
	// Receivers
	// --------------------

	for (genvar i = 0; i < N; i++) begin : g_rx
		uart_rx u_rx (
			.clk        (clk),
			.rst_n      (rst_n),
			.rx         (rx[i]),
			.byte_valid (byte_valid[i]),
			.frame_err  (frame_err[i]),
			.data       (rx_data[i])
		);
	end

	// --------------------
	// Arbiter and FIFO
	// --------------------

	rx_arbiter u_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_valid (byte_valid),
		.frame_err  (frame_err),
		.data       (rx_data),
		.full       (full),
		.push       (push),
		.push_entry (push_entry),
		.overrun    (overrun)
	);

	rx_fifo u_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (push),
		.push_entry (push_entry),
		.rd_en      (rd_en),
		.head       (entry),
		.empty      (empty),
		.full       (full)
	);

endmodule

// ==== bench/tb_uart_hub.sv ====
`timescale 1ns/1ps

`include "uart_config.svh"

module tb_uart_hub;

	import uart_pkg::*;

	localparam int N            = `UART_CHANNELS;
	localparam int DEPTH        = `RX_FIFO_DEPTH;
	localparam int CLKS_PER_BIT = `CLK_FREQ / `BAUD_RATE;
	localparam int IDLE_CLKS    = 2 * CLKS_PER_BIT;
	localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT + IDLE_CLKS;
	localparam int BURST        = 10;
	localparam int TOTAL_FRAMES = 20 + 10 + 2 * BURST + DEPTH + 2;
	localparam int CYCLE_LIMIT  = TOTAL_FRAMES * FRAME_CLKS * 2 + 2000;

	logic         clk = 1'b0;
	logic         rst_n;
	logic [N-1:0] rx;
	logic         rd_en = 1'b0;
	rx_entry_t    entry;
	logic         empty;
	logic [N-1:0] overrun;

	logic [15:0]  lfsr = 16'd19;
	logic         drain_en = 1'b0;
	rx_entry_t    exp_q [N][$];
	int           cycle_count = 0;
	int           err_count = 0;
	int           test_err_start = 0;
	int           tests_run = 0;
	int           tests_failed = 0;
	int           read_count = 0;
	logic [7:0]   burst_a [BURST];
	logic [7:0]   burst_b [BURST];
	logic [BURST-1:0] stop_a;
	logic [BURST-1:0] stop_b;
	logic [7:0]   rand_val;

	uart_hub_top dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx      (rx),
		.rd_en   (rd_en),
		.entry   (entry),
		.empty   (empty),
		.overrun (overrun)
	);

	always #4 clk = ~clk;

	// Watchdog sized from the total frame time
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped producing entries", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// --------------------
	// Random source
	// --------------------

	// 16 bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	// --------------------
	// Line driver and model
	// --------------------

	// Start bit, eight data bits LSB first, stop bit, then idle
	task automatic send_frame(input int ch, input logic [7:0] b, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			rx[ch] = bits[i];
			repeat (CLKS_PER_BIT - 1) @(negedge clk);
		end
		@(negedge clk);
		rx[ch] = 1'b1;
		repeat (IDLE_CLKS - 1) @(negedge clk);
	endtask

	task automatic expect_entry(input int ch, input logic [7:0] b, input logic stop_bit);
		rx_entry_t e;
		e.chan      = chan_t'(ch);
		e.frame_err = !stop_bit;
		e.data      = b;
		exp_q[ch].push_back(e);
	endtask

	task automatic check_entry(input rx_entry_t got);
		rx_entry_t want;
		int        ch;
		ch = int'(got.chan);
		read_count++;
		if (exp_q[ch].size() == 0) begin
			$display("Entry from channel %0d arrived with nothing expected on it", ch);
			err_count++;
		end else begin
			want = exp_q[ch].pop_front();
			if (got.frame_err !== want.frame_err) begin
				$display("FAIL ch%0d entry.frame_err: got %h expected %h",
				         ch, got.frame_err, want.frame_err);
				err_count++;
			end
			if (got.data !== want.data) begin
				$display("FAIL ch%0d entry.data: got %h expected %h", ch, got.data, want.data);
				err_count++;
			end
		end
	endtask

	// Host side, one pop per cycle while entries are present
	always @(negedge clk) begin
		if (drain_en && !empty) begin
			check_entry(entry);
			rd_en = 1'b1;
		end else begin
			rd_en = 1'b0;
		end
	end

	function automatic logic queues_empty();
		for (int c = 0; c < N; c++)
			if (exp_q[c].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic wait_drained();
		do
			@(negedge clk);
		while (!(queues_empty() && empty));
	endtask

	task automatic check_overrun(input logic [N-1:0] want);
		if (overrun !== want) begin
			$display("FAIL overrun: got %h expected %h", overrun, want);
			err_count++;
		end
	endtask

	// --------------------
	// Test bookkeeping
	// --------------------

	task automatic begin_test();
		test_err_start = err_count;
		read_count     = 0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_count == test_err_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors",
			         tests_run, name, err_count - test_err_start);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		rx    = '1;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		// Reset state
		begin_test();
		@(negedge clk);
		if (empty !== 1'b1) begin
			$display("FAIL empty: got %h expected %h", empty, 1'b1);
			err_count++;
		end
		check_overrun('0);
		end_test("reset state");

		drain_en = 1'b1;

		// Good frames on channel 0
		begin_test();
		for (int i = 0; i < 20; i++) begin
			take_bits(8, rand_val);
			expect_entry(0, rand_val, 1'b1);
			send_frame(0, rand_val, 1'b1);
		end
		wait_drained();
		end_test("channel 0 good frames");

		// Bad stop bit on channel 1
		begin_test();
		for (int i = 0; i < 10; i++) begin
			take_bits(8, rand_val);
			expect_entry(1, rand_val, 1'b0);
			send_frame(1, rand_val, 1'b0);
		end
		wait_drained();
		end_test("channel 1 frame errors");

		// Both channels at once, stop bits random too
		begin_test();
		for (int i = 0; i < BURST; i++) begin
			take_bits(1, rand_val);
			stop_a[i] = rand_val[0];
			take_bits(1, rand_val);
			stop_b[i] = rand_val[0];
		end
		for (int i = 0; i < BURST; i++) begin
			take_bits(8, rand_val);
			burst_a[i] = rand_val;
			take_bits(8, rand_val);
			burst_b[i] = rand_val;
			expect_entry(0, burst_a[i], stop_a[i]);
			expect_entry(1, burst_b[i], stop_b[i]);
		end
		fork
			begin
				for (int i = 0; i < BURST; i++)
					send_frame(0, burst_a[i], stop_a[i]);
			end
			begin
				for (int j = 0; j < BURST; j++)
					send_frame(1, burst_b[j], stop_b[j]);
			end
		join
		wait_drained();
		check_overrun('0);
		end_test("two channel contention");

		// FIFO full, one frame held, the last one is an overrun
		begin_test();
		@(negedge clk);
		drain_en = 1'b0;
		for (int i = 0; i < DEPTH + 2; i++) begin
			take_bits(8, rand_val);
			if (i < DEPTH + 1)
				expect_entry(0, rand_val, 1'b1);
			send_frame(0, rand_val, 1'b1);
		end
		while (!overrun[0])
			@(negedge clk);
		check_overrun(N'(1));
		drain_en = 1'b1;
		wait_drained();
		if (read_count != DEPTH + 1) begin
			$display("FAIL read count: got %h expected %h", read_count, DEPTH + 1);
			err_count++;
		end
		end_test("back-pressure and overrun");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+common
common/uart_pkg.sv
uart_rx/uart_rx.sv
source/rx_arbiter.sv
source/rx_fifo.sv
source/uart_hub_top.sv
bench/tb_uart_hub.sv
